// File: Bender.yml
package:
  name: mdll_dac

sources:
  - design/mdll_pkg.sv
  - design/mdll_dac_regs.sv
  - design/mdll_sdm_ctrl_fsm.sv
  - design/mdll_settle_timer.sv
  - design/mdll_prbs19.sv
  - design/mdll_sdm1_multibit.sv
  - design/mdll_dac_sdm.sv
  - design/mdll_dac_top.sv
  - target: test
    files:
      - testbench/mdll_dac_tb.sv

// File: design/mdll_dac_regs.sv
`timescale 1ns/1ps

module mdll_dac_regs (
	input  logic                 clk,
	input  logic                 arst_n,
	input  mdll_pkg::axil_req_t  axil_req,
	input  mdll_pkg::sdm_state_e state,
	output mdll_pkg::axil_rsp_t  axil_rsp,
	output mdll_pkg::sdm_cfg_t   cfg
);
	import mdll_pkg::*;

	// write side
	logic              aw_held;
	logic              w_held;
	logic [AXI_AW-1:0] aw_addr_q;
	logic [AXI_DW-1:0] w_data_q;
	logic [AXI_SW-1:0] w_strb_q;
	logic              bvalid_q;
	logic              awready;
	logic              wready;
	logic              aw_hs;
	logic              w_hs;
	logic              wr_fire;
	logic [AXI_AW-1:0] wr_addr;
	logic [AXI_DW-1:0] wr_data;
	logic [AXI_SW-1:0] wr_strb;
	// read side
	logic              rvalid_q;
	logic [AXI_DW-1:0] rdata_q;
	logic              arready;
	logic              ar_hs;
	logic [AXI_DW-1:0] rd_word;

	// ---------------------------------------------------------------------
	// write channel
	// ---------------------------------------------------------------------

	// one beat of each kind may wait, nothing new while a response is pending
	assign awready = !bvalid_q && !aw_held;
	assign wready  = !bvalid_q && !w_held;
	assign aw_hs   = axil_req.awvalid && awready;
	assign w_hs    = axil_req.wvalid && wready;
	// address and data both present, held or live
	assign wr_fire = (aw_held || aw_hs) && (w_held || w_hs);
	assign wr_addr = aw_held ? aw_addr_q : axil_req.awaddr;
	assign wr_data = w_held ? w_data_q : axil_req.wdata;
	assign wr_strb = w_held ? w_strb_q : axil_req.wstrb;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			aw_held  <= 1'b0;
			w_held   <= 1'b0;
			bvalid_q <= 1'b0;
		end else begin
			aw_held <= (aw_held || aw_hs) && !wr_fire;
			w_held  <= (w_held || w_hs) && !wr_fire;
			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;
		end
	end

	// beat capture
	always_ff @(posedge clk) begin
		if (aw_hs)
			aw_addr_q <= axil_req.awaddr;
		if (w_hs) begin
			w_data_q <= axil_req.wdata;
			w_strb_q <= axil_req.wstrb;
		end
	end

	// register file, byte strobes per bit
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cfg <= '0;
		end else if (wr_fire) begin
			case (wr_addr)
				REG_CTRL: begin
					if (wr_strb[0]) begin
						cfg.en       <= wr_data[CTRL_EN_BIT];
						cfg.dith_en  <= wr_data[CTRL_DITH_BIT];
						cfg.prbs_mag <= wr_data[CTRL_MAG_LSB +: N_PRBS_MAG];
					end
				end
				REG_DIN: begin
					for (int i = 0; i < N_DAC_TF; i++)
						if (wr_strb[i/8])
							cfg.din[i] <= wr_data[i];
				end
				REG_SETTLE: begin
					for (int i = 0; i < N_SETTLE; i++)
						if (wr_strb[i/8])
							cfg.settle_cycles[i] <= wr_data[i];
				end
				// status and unmapped, dropped
				default: ;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// read channel
	// ---------------------------------------------------------------------

	assign arready = !rvalid_q;
	assign ar_hs   = axil_req.arvalid && arready;

	always_comb begin
		rd_word = '0;
		case (axil_req.araddr)
			REG_CTRL: begin
				rd_word[CTRL_EN_BIT]                 = cfg.en;
				rd_word[CTRL_DITH_BIT]               = cfg.dith_en;
				rd_word[CTRL_MAG_LSB +: N_PRBS_MAG]  = cfg.prbs_mag;
			end
			REG_DIN:    rd_word[N_DAC_TF-1:0] = cfg.din;
			REG_SETTLE: rd_word[N_SETTLE-1:0] = cfg.settle_cycles;
			// live fsm state
			REG_STATUS: rd_word[1:0] = state;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rvalid_q <= 1'b0;
		else if (ar_hs)
			rvalid_q <= 1'b1;
		else if (axil_req.rready)
			rvalid_q <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ar_hs)
			rdata_q <= rd_word;
	end

	always_comb begin
		axil_rsp.awready = awready;
		axil_rsp.wready  = wready;
		axil_rsp.bresp   = AXI_RESP_OKAY;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.arready = arready;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = AXI_RESP_OKAY;
		axil_rsp.rvalid  = rvalid_q;
	end

	// responses wait for the master
	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid);
	a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata));

endmodule

// File: design/mdll_dac_sdm.sv
`timescale 1ns/1ps

module mdll_dac_sdm #(
	parameter int N_DAC_TF       = mdll_pkg::N_DAC_TF,
	parameter int N_DAC_FRAC     = mdll_pkg::N_DAC_FRAC,
	parameter int RST_SYNC_DEPTH = mdll_pkg::RST_SYNC_DEPTH
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            sdm_run,
	input  logic                            dith_en,
	input  logic [mdll_pkg::N_PRBS_MAG-1:0] prbs_mag,
	input  logic [N_DAC_TF-1:0]             din,
	output logic [N_DAC_TF-N_DAC_FRAC:0]    dout_sdm
);

	logic [RST_SYNC_DEPTH-1:0]  rst_sync_q;
	logic                       rstn_sync;
	logic                       rstn_mod;
	logic signed [N_DAC_TF-1:0] dith_prbs;
	logic signed [N_DAC_TF-1:0] dither;

	// ---------------------------------------------------------------------
	// local reset
	// ---------------------------------------------------------------------

	// async assert, release after RST_SYNC_DEPTH clocks
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			rst_sync_q <= '0;
		else
			rst_sync_q <= (rst_sync_q << 1) | RST_SYNC_DEPTH'(1);
	end

	assign rstn_sync = rst_sync_q[RST_SYNC_DEPTH-1];
	// sdm_run is a flop in this domain, so its rise is already synchronous
	assign rstn_mod = rstn_sync & sdm_run;

	// ---------------------------------------------------------------------
	// dither and modulator
	// ---------------------------------------------------------------------

	// restarts from its seed on every run
	mdll_prbs19 #(
		.N_DI(N_DAC_TF)
	) u_prbs (
		.clk     (clk),
		.arst_n  (rstn_mod),
		.prbs_mag(prbs_mag),
		.dith_out(dith_prbs)
	);

	assign dither = dith_en ? dith_prbs : '0;

	mdll_sdm1_multibit #(
		.N_DI  (N_DAC_TF),
		.N_FRAC(N_DAC_FRAC)
	) u_mash1 (
		.clk   (clk),
		.arst_n(rstn_mod),
		.din   (din),
		.dither(dither),
		.dout  (dout_sdm)
	);

	// fsm never lets the modulator run before the sync chain has released
	a_run_after_sync: assert property (@(posedge clk) disable iff (!arst_n)
		sdm_run |-> rstn_sync);

endmodule

// File: design/mdll_dac_top.sv
`timescale 1ns/1ps

module mdll_dac_top #(
	parameter int N_DAC_TF       = mdll_pkg::N_DAC_TF,
	parameter int N_DAC_FRAC     = mdll_pkg::N_DAC_FRAC,
	parameter int N_SETTLE       = mdll_pkg::N_SETTLE,
	parameter int RST_SYNC_DEPTH = mdll_pkg::RST_SYNC_DEPTH
) (
	input  logic                         clk,
	input  logic                         arst_n,
	input  mdll_pkg::axil_req_t          axil_req,
	output mdll_pkg::axil_rsp_t          axil_rsp,
	output logic [N_DAC_TF-N_DAC_FRAC:0] dout_sdm
);
	import mdll_pkg::*;

	sdm_cfg_t   cfg;
	sdm_state_e state;
	logic       timer_load;
	logic       timer_done;
	logic       sdm_run;

	// register port
	mdll_dac_regs u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.axil_req(axil_req),
		.state   (state),
		.axil_rsp(axil_rsp),
		.cfg     (cfg)
	);

	// hold length tracks the reset sync depth
	mdll_sdm_ctrl_fsm #(
		.RST_HOLD(RST_SYNC_DEPTH)
	) u_fsm (
		.clk       (clk),
		.arst_n    (arst_n),
		.en        (cfg.en),
		.timer_done(timer_done),
		.timer_load(timer_load),
		.sdm_run   (sdm_run),
		.state     (state)
	);

	mdll_settle_timer #(
		.N_CNT(N_SETTLE)
	) u_timer (
		.clk   (clk),
		.arst_n(arst_n),
		.load  (timer_load),
		.cycles(cfg.settle_cycles),
		.done  (timer_done)
	);

	mdll_dac_sdm #(
		.N_DAC_TF      (N_DAC_TF),
		.N_DAC_FRAC    (N_DAC_FRAC),
		.RST_SYNC_DEPTH(RST_SYNC_DEPTH)
	) u_sdm (
		.clk     (clk),
		.arst_n  (arst_n),
		.sdm_run (sdm_run),
		.dith_en (cfg.dith_en),
		.prbs_mag(cfg.prbs_mag),
		.din     (cfg.din),
		.dout_sdm(dout_sdm)
	);

endmodule

// File: design/mdll_pkg.sv
package mdll_pkg;

	// ---------------------------------------------------------------------
	// datapath widths
	// ---------------------------------------------------------------------

	// din word, integer plus fractional bits
	localparam int N_DAC_TF = 14;
	// fractional bits seen by the accumulator
	localparam int N_DAC_FRAC = 10;
	// output code, one extra bit for the carry
	localparam int N_DAC_DITH = N_DAC_TF - N_DAC_FRAC + 1;
	// dither magnitude field
	localparam int N_PRBS_MAG = $clog2(N_DAC_FRAC);
	// settle counter width
	localparam int N_SETTLE = 16;
	// reset sync flops, also the reset hold length
	localparam int RST_SYNC_DEPTH = 2;

	// ---------------------------------------------------------------------
	// axi4-lite and register map
	// ---------------------------------------------------------------------

	localparam int AXI_AW = 4;
	localparam int AXI_DW = 32;
	localparam int AXI_SW = AXI_DW / 8;
	localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

	localparam logic [AXI_AW-1:0] REG_CTRL   = 4'h0;
	localparam logic [AXI_AW-1:0] REG_DIN    = 4'h4;
	localparam logic [AXI_AW-1:0] REG_SETTLE = 4'h8;
	// read only
	localparam logic [AXI_AW-1:0] REG_STATUS = 4'hc;

	// field positions in REG_CTRL
	localparam int CTRL_EN_BIT   = 0;
	localparam int CTRL_DITH_BIT = 1;
	localparam int CTRL_MAG_LSB  = 4;

	// enable sequencing states
	typedef enum logic [1:0] {
		ST_IDLE     = 2'd0,
		ST_RST_HOLD = 2'd1,
		ST_SETTLE   = 2'd2,
		ST_RUN      = 2'd3
	} sdm_state_e;

	// register contents as seen by the datapath
	typedef struct packed {
		logic                  en;
		logic                  dith_en;
		logic [N_PRBS_MAG-1:0] prbs_mag;
		logic [N_DAC_TF-1:0]   din;
		logic [N_SETTLE-1:0]   settle_cycles;
	} sdm_cfg_t;

	// master to slave
	typedef struct packed {
		logic [AXI_AW-1:0] awaddr;
		logic              awvalid;
		logic [AXI_DW-1:0] wdata;
		logic [AXI_SW-1:0] wstrb;
		logic              wvalid;
		logic              bready;
		logic [AXI_AW-1:0] araddr;
		logic              arvalid;
		logic              rready;
	} axil_req_t;

	// slave to master
	typedef struct packed {
		logic              awready;
		logic              wready;
		logic [1:0]        bresp;
		logic              bvalid;
		logic              arready;
		logic [AXI_DW-1:0] rdata;
		logic [1:0]        rresp;
		logic              rvalid;
	} axil_rsp_t;

endpackage

// File: design/mdll_prbs19.sv
`timescale 1ns/1ps

module mdll_prbs19 #(
	parameter int N_DI = mdll_pkg::N_DAC_TF
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [mdll_pkg::N_PRBS_MAG-1:0] prbs_mag,
	output logic signed [N_DI-1:0]          dith_out
);

	localparam logic [18:0] SEED = 19'h5a5a3;
	// usable random bits
	localparam int N_TAKE = (N_DI < 19) ? N_DI : 19;

	logic [18:0]            lfsr;
	logic                   feedback;
	logic [N_DI-1:0]        raw;
	logic signed [N_DI-1:0] raw_shl;
	int                     mag;
	int                     shamt;

	// x^19 + x^18 + x^17 + x^14 + 1
	assign feedback = lfsr[18] ^ lfsr[17] ^ lfsr[16] ^ lfsr[13];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			lfsr <= SEED;
		else
			lfsr <= {lfsr[17:0], feedback};
	end

	// keep mag low bits, sign extend from bit mag-1
	always_comb begin
		mag      = (int'(prbs_mag) > N_TAKE) ? N_TAKE : int'(prbs_mag);
		shamt    = N_DI - mag;
		raw      = N_DI'(lfsr);
		raw_shl  = $signed(raw << shamt);
		if (mag == 0)
			dith_out = '0;
		else
			dith_out = raw_shl >>> shamt;
	end

	// lock-up state never entered
	a_lfsr_alive: assert property (@(posedge clk) disable iff (!arst_n)
		lfsr != '0);

endmodule

// File: design/mdll_sdm1_multibit.sv
`timescale 1ns/1ps

module mdll_sdm1_multibit #(
	parameter int N_DI   = mdll_pkg::N_DAC_TF,
	parameter int N_FRAC = mdll_pkg::N_DAC_FRAC
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic [N_DI-1:0]        din,
	input  logic signed [N_DI-1:0] dither,
	output logic [N_DI-N_FRAC:0]   dout
);

	localparam int N_DO  = N_DI - N_FRAC + 1;
	// room for frac + acc + negative dither
	localparam int N_SUM = N_DI + 2;

	logic [N_FRAC-1:0]       acc;
	logic [N_DO-1:0]         din_int;
	logic signed [N_SUM-1:0] sum;
	logic signed [N_SUM-1:0] carry;
	logic [N_DO-1:0]         dout_next;

	// ---------------------------------------------------------------------
	// first order error feedback
	// ---------------------------------------------------------------------

	// integer part, top bit left free for the carry
	assign din_int = {1'b0, din[N_DI-1:N_FRAC]};

	assign sum = $signed(N_SUM'(acc)) + $signed(N_SUM'(din[N_FRAC-1:0])) + N_SUM'(dither);

	// overflow out of the accumulator, negative on a borrow
	assign carry = sum >>> N_FRAC;

	assign dout_next = din_int + carry[N_DO-1:0];

	// residue stays in acc
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			acc  <= '0;
			dout <= '0;
		end else begin
			acc  <= sum[N_FRAC-1:0];
			dout <= dout_next;
		end
	end

	// without dither the code only toggles between I and I+1
	a_no_dither_range: assert property (@(posedge clk) disable iff (!arst_n)
		dither == '0 |=> (dout == $past(din_int)) || (dout == $past(din_int) + 1));

endmodule

// File: design/mdll_sdm_ctrl_fsm.sv
`timescale 1ns/1ps

module mdll_sdm_ctrl_fsm #(
	parameter int RST_HOLD = mdll_pkg::RST_SYNC_DEPTH
) (
	input  logic                 clk,
	input  logic                 arst_n,
	input  logic                 en,
	input  logic                 timer_done,
	output logic                 timer_load,
	output logic                 sdm_run,
	output mdll_pkg::sdm_state_e state
);
	import mdll_pkg::*;

	localparam int N_HOLD = ($clog2(RST_HOLD) > 0) ? $clog2(RST_HOLD) : 1;
	localparam logic [N_HOLD-1:0] HOLD_LAST = N_HOLD'(RST_HOLD - 1);

	sdm_state_e        state_next;
	logic [N_HOLD-1:0] hold_cnt;

	// ---------------------------------------------------------------------
	// next state
	// ---------------------------------------------------------------------

	always_comb begin
		state_next = state;
		timer_load = 1'b0;
		// en low wins from any state
		if (!en) begin
			state_next = ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: state_next = ST_RST_HOLD;
				ST_RST_HOLD: begin
					// last hold cycle, arm the settle timer
					if (hold_cnt == HOLD_LAST) begin
						state_next = ST_SETTLE;
						timer_load = 1'b1;
					end
				end
				ST_SETTLE: begin
					if (timer_done)
						state_next = ST_RUN;
				end
				ST_RUN: state_next = ST_RUN;
				default: state_next = ST_IDLE;
			endcase
		end
	end

	// ---------------------------------------------------------------------
	// state, hold count, run flag
	// ---------------------------------------------------------------------

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= ST_IDLE;
			hold_cnt <= '0;
			sdm_run  <= 1'b0;
		end else begin
			state <= state_next;
			// counts only inside the hold state
			if (state == ST_RST_HOLD)
				hold_cnt <= hold_cnt + 1'b1;
			else
				hold_cnt <= '0;
			// registered so the modulator reset sees a clean edge
			sdm_run <= (state_next == ST_RUN);
		end
	end

	// reset hold lasts exactly RST_HOLD cycles
	a_hold_length: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(state == ST_SETTLE) |->
		$past(state == ST_RST_HOLD, RST_HOLD) && $past(state != ST_RST_HOLD, RST_HOLD + 1));

endmodule

// File: design/mdll_settle_timer.sv
`timescale 1ns/1ps

module mdll_settle_timer #(
	parameter int N_CNT = mdll_pkg::N_SETTLE
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             load,
	input  logic [N_CNT-1:0] cycles,
	output logic             done
);

	logic [N_CNT-1:0] cnt;

	// down count, parks at zero
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			cnt <= '0;
		end else if (load) begin
			// zero still settles for one cycle
			cnt <= (cycles == '0) ? N_CNT'(1) : cycles;
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	// last loaded cycle
	assign done = (cnt == N_CNT'(1));

	a_done_pulse: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done);

endmodule

// File: sources.f
design/mdll_pkg.sv
design/mdll_dac_regs.sv
design/mdll_sdm_ctrl_fsm.sv
design/mdll_settle_timer.sv
design/mdll_prbs19.sv
design/mdll_sdm1_multibit.sv
design/mdll_dac_sdm.sv
design/mdll_dac_top.sv
testbench/mdll_dac_tb.sv

// File: testbench/mdll_dac_tb.sv
`timescale 1ns/1ps

module mdll_dac_tb;
	import mdll_pkg::*;

	localparam int N_PERIOD = 2 ** N_DAC_FRAC;
	// one full period plus room for sliding windows
	localparam int N_CAP = N_PERIOD + 256;
	localparam logic [31:0] CTRL_MASK = 32'h0000_00f3;
	localparam logic [31:0] DIN_MASK = (32'd1 << N_DAC_TF) - 1;
	localparam logic [31:0] SETTLE_MASK = 32'h0000_ffff;
	localparam logic [31:0] LFSR_SEED = 32'h07b6cc96;
	// per test budgets in cycles
	localparam int T_REGS = 400;
	localparam int T_SEQ = 600;
	localparam int T_AVG = 3200;
	localparam int T_INT = 2000;
	localparam int T_DITH = 3200;
	localparam int T_BP = 400;
	localparam int CYCLE_LIMIT = T_REGS + T_SEQ + T_AVG + T_INT + T_DITH + T_BP + 2200;

	logic                  clk;
	logic                  arst_n;
	axil_req_t             axil_req;
	axil_rsp_t             axil_rsp;
	logic [N_DAC_DITH-1:0] dout_sdm;

	logic [31:0]           lfsr_state;
	int                    cycles = 0;
	int                    errors = 0;
	int                    tests_run = 0;
	int                    tests_failed = 0;
	int                    test_err0;
	// snapshot taken when read data is sampled
	logic [N_DAC_DITH-1:0] last_rd_dout;
	int                    last_rd_cycle;
	logic [N_DAC_DITH-1:0] samples[$];
	logic [N_DAC_DITH-1:0] ref_samples[$];

	mdll_dac_top #(
		.N_DAC_TF      (N_DAC_TF),
		.N_DAC_FRAC    (N_DAC_FRAC),
		.N_SETTLE      (N_SETTLE),
		.RST_SYNC_DEPTH(RST_SYNC_DEPTH)
	) dut0 (
		.clk     (clk),
		.arst_n  (arst_n),
		.axil_req(axil_req),
		.axil_rsp(axil_rsp),
		.dout_sdm(dout_sdm)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// watchdog
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles, a test did not finish", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ---------------------------------------------------------------------
	// protocol checks
	// ---------------------------------------------------------------------

	a_bvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
	else begin
		$display("%0t ns: bvalid or bresp changed before bready", $time);
		errors++;
	end

	a_rvalid_hold: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.rvalid && !axil_req.rready |=>
		axil_rsp.rvalid && $stable(axil_rsp.rdata) && $stable(axil_rsp.rresp))
	else begin
		$display("%0t ns: rvalid or read data changed before rready", $time);
		errors++;
	end

	// pending response blocks any new write beat
	a_no_accept: assert property (@(posedge clk) disable iff (!arst_n)
		axil_rsp.bvalid |-> !axil_rsp.awready && !axil_rsp.wready)
	else begin
		$display("%0t ns: write beat accepted while a response was pending", $time);
		errors++;
	end

	// ---------------------------------------------------------------------
	// helpers
	// ---------------------------------------------------------------------

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] next_lfsr(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = next_lfsr(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERROR %0t ns %s expected 0x%0h actual 0x%0h", $time, sig, exp, act);
			errors++;
		end
	endtask

	task automatic check_true(input bit cond, input string what);
		assert (cond) else begin
			$display("%0t ns: %s", $time, what);
			errors++;
		end
	endtask

	task automatic begin_test();
		test_err0 = errors;
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (errors > test_err0) begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - test_err0);
		end else begin
			$display("test %s: ok", name);
		end
	endtask

	// ---------------------------------------------------------------------
	// axi4-lite master
	// ---------------------------------------------------------------------

	// address may trail data by aw_lag cycles
	task automatic send_write_beats(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int aw_lag);
		bit aw_done;
		bit w_done;
		int lag;
		aw_done = 1'b0;
		w_done = 1'b0;
		lag = aw_lag;
		@(negedge clk);
		axil_req.awaddr = addr;
		axil_req.wdata = data;
		axil_req.wstrb = strb;
		axil_req.wvalid = 1'b1;
		axil_req.awvalid = (lag == 0);
		while (!(aw_done && w_done)) begin
			// readies are registered, so this is what the next edge sees
			if (axil_req.awvalid && axil_rsp.awready)
				aw_done = 1'b1;
			if (axil_req.wvalid && axil_rsp.wready)
				w_done = 1'b1;
			@(negedge clk);
			if (lag > 0)
				lag--;
			axil_req.awvalid = !aw_done && (lag == 0);
			if (w_done)
				axil_req.wvalid = 1'b0;
		end
	endtask

	task automatic take_write_resp(input int hold);
		while (!axil_rsp.bvalid)
			@(negedge clk);
		repeat (hold) @(negedge clk);
		check_value("bresp", AXI_RESP_OKAY, axil_rsp.bresp);
		axil_req.bready = 1'b1;
		@(negedge clk);
		axil_req.bready = 1'b0;
	endtask

	task automatic axi_write(input logic [AXI_AW-1:0] addr, input logic [31:0] data,
		input logic [3:0] strb);
		send_write_beats(addr, data, strb, take_bits(2));
		take_write_resp(take_bits(3));
	endtask

	task automatic axi_read_hold(input logic [AXI_AW-1:0] addr, input int hold,
		output logic [31:0] data);
		@(negedge clk);
		axil_req.araddr = addr;
		axil_req.arvalid = 1'b1;
		while (!axil_rsp.arready)
			@(negedge clk);
		@(negedge clk);
		axil_req.arvalid = 1'b0;
		check_true(axil_rsp.rvalid, "no rvalid the cycle after the read address");
		repeat (hold) @(negedge clk);
		data = axil_rsp.rdata;
		last_rd_dout = dout_sdm;
		last_rd_cycle = cycles;
		check_value("rresp", AXI_RESP_OKAY, axil_rsp.rresp);
		axil_req.rready = 1'b1;
		@(negedge clk);
		axil_req.rready = 1'b0;
	endtask

	task automatic read_expect(input logic [AXI_AW-1:0] addr, input logic [31:0] exp,
		input string sig);
		logic [31:0] d;
		axi_read_hold(addr, take_bits(3), d);
		check_value(sig, exp, d);
	endtask

	// ---------------------------------------------------------------------
	// modulator runs
	// ---------------------------------------------------------------------

	task automatic run_and_capture(input int i_part, input int f_part, input logic [31:0] ctrl,
		input int n);
		int wait_cyc;
		axi_write(REG_CTRL, 32'h0, 4'hf);
		axi_write(REG_DIN, (i_part << N_DAC_FRAC) | f_part, 4'hf);
		// long enough that the write returns before the first code
		axi_write(REG_SETTLE, 16 + take_bits(4), 4'hf);
		axi_write(REG_CTRL, ctrl | 32'h1, 4'hf);
		samples.delete();
		wait_cyc = 0;
		// first nonzero code marks the first running cycle
		while (dout_sdm == '0 && wait_cyc < 100) begin
			@(negedge clk);
			wait_cyc++;
		end
		check_true(dout_sdm != '0, "modulator output never left zero");
		repeat (n) begin
			samples.push_back(dout_sdm);
			@(negedge clk);
		end
	endtask

	task automatic check_average(input int i_part, input int f_part);
		int  win;
		bit  range_bad;
		bit  sum_bad;
		win = 0;
		range_bad = 1'b0;
		sum_bad = 1'b0;
		for (int k = 0; k < samples.size(); k++) begin
			win += samples[k];
			if (k >= N_PERIOD)
				win -= samples[k - N_PERIOD];
			if (!range_bad && samples[k] != i_part && samples[k] != i_part + 1) begin
				check_value("dout_sdm", i_part, samples[k]);
				range_bad = 1'b1;
			end
			if (!sum_bad && k >= N_PERIOD - 1 && win != i_part * N_PERIOD + f_part) begin
				check_value("dout_sdm window sum", i_part * N_PERIOD + f_part, win);
				sum_bad = 1'b1;
			end
		end
	endtask

	// ---------------------------------------------------------------------
	// tests
	// ---------------------------------------------------------------------

	initial begin
		logic [31:0] d1;
		logic [31:0] d2;
		logic [31:0] st;
		int          s;
		int          t_done;
		int          ri;
		int          rf;
		int          cnt;
		bit          bad;
		bit          differs;

		lfsr_state = LFSR_SEED;
		axil_req = '0;
		arst_n = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// 1 register readback
		begin_test();
		check_value("bvalid", 0, axil_rsp.bvalid);
		check_value("rvalid", 0, axil_rsp.rvalid);
		check_value("dout_sdm", 0, dout_sdm);
		read_expect(REG_STATUS, ST_IDLE, "status");
		d1 = take_bits(32) & ~32'h1;
		axi_write(REG_CTRL, d1, 4'hf);
		read_expect(REG_CTRL, d1 & CTRL_MASK, "ctrl");
		// no byte 0 strobe, ctrl unchanged
		axi_write(REG_CTRL, 32'hffff_ffff, 4'b1110);
		read_expect(REG_CTRL, d1 & CTRL_MASK, "ctrl");
		d1 = take_bits(32);
		axi_write(REG_DIN, d1, 4'hf);
		read_expect(REG_DIN, d1 & DIN_MASK, "din");
		d2 = take_bits(32);
		axi_write(REG_DIN, d2, 4'b0010);
		read_expect(REG_DIN, ((d1 & 32'hff) | (d2 & 32'hff00)) & DIN_MASK, "din");
		d1 = take_bits(32);
		axi_write(REG_SETTLE, d1, 4'hf);
		read_expect(REG_SETTLE, d1 & SETTLE_MASK, "settle");
		d2 = take_bits(32);
		axi_write(REG_SETTLE, d2, 4'b0001);
		read_expect(REG_SETTLE, (d1 & 32'hff00) | (d2 & 32'hff), "settle");
		axi_write(4'h6, 32'hdead_beef, 4'hf);
		read_expect(4'h6, 32'h0, "unmapped");
		axi_write(REG_STATUS, 32'hffff_ffff, 4'hf);
		read_expect(REG_STATUS, ST_IDLE, "status");
		end_test("register readback");

		// 2 enable sequencing
		begin_test();
		axi_write(REG_CTRL, 32'h0, 4'hf);
		axi_write(REG_DIN, (5 << N_DAC_FRAC) | 300, 4'hf);
		for (int run = 0; run < 2; run++) begin
			s = (run == 0) ? 0 : take_bits(6);
			axi_write(REG_SETTLE, s, 4'hf);
			send_write_beats(REG_CTRL, 32'h1, 4'hf, 0);
			take_write_resp(0);
			t_done = cycles;
			st = ST_IDLE;
			last_rd_cycle = cycles;
			while (st != ST_RUN && last_rd_cycle - t_done <= s + 40) begin
				axi_read_hold(REG_STATUS, 0, st);
				if (st != ST_RUN)
					check_value("dout_sdm", 0, last_rd_dout);
			end
			check_true(st == ST_RUN, "status never reached ST_RUN");
			// status word holds the state of the cycle before its capture edge
			check_true(last_rd_cycle - 1 - t_done >= RST_SYNC_DEPTH + s,
				"ST_RUN reached before reset hold and settle time");
			axi_write(REG_CTRL, 32'h0, 4'hf);
			read_expect(REG_STATUS, ST_IDLE, "status");
			check_value("dout_sdm", 0, dout_sdm);
		end
		end_test("enable sequencing");

		// 3 average equals input
		begin_test();
		run_and_capture(7, 1, 32'h0, N_CAP);
		check_average(7, 1);
		ri = 2 + take_bits(4) % 13;
		rf = 1 + take_bits(10) % (N_PERIOD - 1);
		run_and_capture(ri, rf, 32'h0, N_CAP);
		check_average(ri, rf);
		ref_samples = samples;
		end_test("average equals input");

		// 4 integer inputs
		begin_test();
		run_and_capture(9, 0, 32'h0, 64);
		bad = 1'b0;
		foreach (samples[k]) begin
			if (!bad && samples[k] != 9) begin
				check_value("dout_sdm", 9, samples[k]);
				bad = 1'b1;
			end
		end
		// largest code, I+1 must still fit the output
		run_and_capture(15, N_PERIOD - 1, 32'h0, N_CAP);
		check_average(15, N_PERIOD - 1);
		cnt = 0;
		for (int k = 0; k < N_PERIOD; k++)
			if (samples[k] == 15)
				cnt++;
		check_value("dout_sdm count of I per period", 1, cnt);
		end_test("integer inputs");

		// 5 dither bounds
		begin_test();
		run_and_capture(ri, rf, 32'h2, N_CAP);
		bad = 1'b0;
		foreach (samples[k]) begin
			if (!bad && samples[k] != ref_samples[k]) begin
				check_value("dout_sdm", ref_samples[k], samples[k]);
				bad = 1'b1;
			end
		end
		run_and_capture(ri, rf, 32'h2 | (32'd3 << CTRL_MAG_LSB), N_CAP);
		bad = 1'b0;
		differs = 1'b0;
		foreach (samples[k]) begin
			if (samples[k] != ref_samples[k])
				differs = 1'b1;
			if (!bad && (samples[k] < ri - 1 || samples[k] > ri + 2)) begin
				check_value("dout_sdm", ri, samples[k]);
				bad = 1'b1;
			end
		end
		check_true(differs, "dithered sequence never differed from the undithered one");
		axi_write(REG_CTRL, 32'h0, 4'hf);
		end_test("dither bounds");

		// 6 axi back-pressure
		begin_test();
		d1 = take_bits(32);
		d2 = take_bits(32);
		send_write_beats(REG_DIN, d1, 4'hf, 0);
		// second write waits behind the held response
		axil_req.awaddr = REG_DIN;
		axil_req.wdata = d2;
		axil_req.wstrb = 4'hf;
		axil_req.awvalid = 1'b1;
		axil_req.wvalid = 1'b1;
		take_write_resp(4 + take_bits(4));
		// held beats go through once the response is gone
		while (!(axil_rsp.awready && axil_rsp.wready))
			@(negedge clk);
		@(negedge clk);
		axil_req.awvalid = 1'b0;
		axil_req.wvalid = 1'b0;
		take_write_resp(4 + take_bits(4));
		axi_read_hold(REG_DIN, 4 + take_bits(4), st);
		check_value("din", d2 & DIN_MASK, st);
		axi_write(REG_SETTLE, d1, 4'hf);
		axi_read_hold(REG_SETTLE, 4 + take_bits(4), st);
		check_value("settle", d1 & SETTLE_MASK, st);
		end_test("axi back-pressure");

		$display("tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
